//--- cartMapperPkg.sv
package cartMapperPkg;

    // ====================
    // Memory port widths
    // ====================

    // 512 banks of 16 KiB in the ROM image
    localparam int ImageAddrWidth = 23;
    // 16 banks of 8 KiB of cartridge RAM
    localparam int RamAddrWidth = 17;

    // Cartridge type byte, ROM size and RAM size follow in order
    localparam logic [15:0] HeaderTypeAddr = 16'h0147;
    // Low nibble that opens the RAM window
    localparam logic [3:0] RamEnableKey = 4'hA;
    // MBC3 clock seconds, minutes, hours, day low, day high
    localparam int RtcRegCount = 5;

    // ====================
    // Enumerations
    // ====================

    typedef enum logic [2:0]
    {
        mapRomOnly,
        mapMbc1,
        mapMbc3,
        mapMbc5,
        mapUnsupported
    } mapperKind_e;

    // Names the header byte on the image bus in that cycle
    typedef enum logic [2:0]
    {
        hdrTypeAddr,
        hdrTypeData,
        hdrRomData,
        hdrRamData,
        hdrDone
    } headerState_e;

    // ====================
    // Structs
    // ====================

    // Host request, valid means cycle and strobe both high
    typedef struct packed
    {
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic        write;
        logic        valid;
    } hostReq_t;

    typedef struct packed
    {
        mapperKind_e kind;
        logic [3:0]  romSize;
        logic [2:0]  ramSize;
        logic        hasRam;
        logic        hasTimer;
    } cartCfg_t;

    typedef struct packed
    {
        logic [8:0] romBank;
        logic [3:0] ramBank;
        logic       ramEnabled;
        logic       bankingMode;
    } bankState_t;

endpackage

//--- cartHeaderDecode.sv
`timescale 1ns/1ps

module cartHeaderDecode
(
    input  logic                    Clk,
    input  logic                    rstN,
    input  logic [7:0]              imageData,
    output logic [15:0]             hdrAddr,
    output logic                    hdrRead,
    output cartMapperPkg::cartCfg_t cfg,
    output logic                    cfgReady
);
    import cartMapperPkg::*;

    headerState_e state;

    // Decode of the type byte while it sits on imageData
    mapperKind_e typeKind;
    logic        typeHasRam;
    logic        typeHasTimer;

    always_comb
    begin
        case (imageData)
            8'h00, 8'h08, 8'h09:
                typeKind = mapRomOnly;
            8'h01, 8'h02, 8'h03:
                typeKind = mapMbc1;
            8'h0F, 8'h10, 8'h11, 8'h12, 8'h13:
                typeKind = mapMbc3;
            8'h19, 8'h1A, 8'h1B, 8'h1C, 8'h1D, 8'h1E:
                typeKind = mapMbc5;
            // MBC2, MMM01, camera, HuC and the rest
            default:
                typeKind = mapUnsupported;
        endcase
    end

    assign typeHasTimer = (imageData == 8'h0F) || (imageData == 8'h10);
    assign typeHasRam = imageData inside {8'h02, 8'h03, 8'h08, 8'h09, 8'h10, 8'h12, 8'h13,
                                          8'h1A, 8'h1B, 8'h1D, 8'h1E};

    // ====================
    // Header sequencer
    // ====================

    // Each byte comes back one cycle after its read strobe
    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            state    <= hdrTypeAddr;
            hdrAddr  <= '0;
            hdrRead  <= 1'b0;
            cfg      <= '0;
            cfgReady <= 1'b0;
        end
        else
        begin
            case (state)
                hdrTypeAddr:
                begin
                    hdrAddr <= HeaderTypeAddr;
                    hdrRead <= 1'b1;
                    state   <= hdrTypeData;
                end
                hdrTypeData:
                begin
                    hdrAddr <= HeaderTypeAddr + 16'd1;
                    state   <= hdrRomData;
                end
                hdrRomData:
                begin
                    // Type byte arrives
                    cfg.kind     <= typeKind;
                    cfg.hasRam   <= typeHasRam;
                    cfg.hasTimer <= typeHasTimer;
                    hdrAddr      <= HeaderTypeAddr + 16'd2;
                    state        <= hdrRamData;
                end
                hdrRamData:
                begin
                    // 0x52 to 0x54 fold into codes 0xC to 0xE
                    cfg.romSize <= imageData[4] ? 4'hA + imageData[3:0] : imageData[3:0];
                    hdrRead     <= 1'b0;
                    state       <= hdrDone;
                end
                hdrDone:
                begin
                    if (!cfgReady)
                    begin
                        // Swap 4 and 5 so 64 KiB sorts below 128 KiB
                        cfg.ramSize <= imageData[2] ? {2'b10, ~imageData[0]} : imageData[2:0];
                        cfgReady    <= 1'b1;
                    end
                end
                default:
                    state <= hdrTypeAddr;
            endcase
        end
    end

    // Image port belongs to the host once configured
    assert property (@(posedge Clk) disable iff (!rstN) cfgReady |-> !hdrRead);

endmodule

//--- bankRegisters.sv
`timescale 1ns/1ps

module bankRegisters
#(
    parameter int RomBankBits = 9
)
(
    input  logic                      Clk,
    input  logic                      rstN,
    input  cartMapperPkg::cartCfg_t   cfg,
    input  cartMapperPkg::hostReq_t   accept,
    input  logic                      rtcSelect,
    output cartMapperPkg::bankState_t banks,
    output logic [7:0]                rtcData
);
    import cartMapperPkg::*;

    logic [15:0] maskWide;
    logic [8:0]  romMask;
    logic [8:0]  bankCandidate;
    logic [8:0]  bankMasked;
    logic        mbcKind;
    logic        regWrite;
    logic        canEnable;
    logic [7:0]  rtcRegs [RtcRegCount];

    assign mbcKind = cfg.kind inside {mapMbc1, mapMbc3, mapMbc5};
    // ROM only and unsupported carts ignore register writes
    assign regWrite = accept.valid && accept.write && !accept.addr[15] && mbcKind;
    // Nothing to open without RAM or a clock
    assign canEnable = cfg.hasRam || cfg.hasTimer;

    // ====================
    // ROM bank mask
    // ====================

    always_comb
    begin
        // Codes 0xC to 0xE sit between 64 and 128 banks
        if (cfg.romSize[3:2] == 2'b11)
            maskWide = 16'd127;
        else
            maskWide = (16'd2 << cfg.romSize) - 16'd1;
    end

    // Also clip to the bank register width
    assign romMask = maskWide[8:0] & 9'((10'd1 << RomBankBits) - 10'd1);

    always_comb
    begin
        if (cfg.kind == mapMbc5)
        begin
            // 0x3000 page carries bit 8
            if (accept.addr[12])
                bankCandidate = {accept.wdata[0], banks.romBank[7:0]};
            else
                bankCandidate = {banks.romBank[8], accept.wdata};
        end
        else if (cfg.kind == mapMbc1)
            bankCandidate = {4'b0000, accept.wdata[4:0]};
        else
            bankCandidate = {2'b00, accept.wdata[6:0]};
        bankMasked = bankCandidate & romMask;
        // MBC1 and MBC3 never map bank 0 in the upper window
        if (cfg.kind == mapMbc1 && bankMasked[4:0] == 5'd0)
            bankMasked[0] = 1'b1;
        if (cfg.kind == mapMbc3 && bankMasked[6:0] == 7'd0)
            bankMasked[0] = 1'b1;
    end

    // ====================
    // Control registers
    // ====================

    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            banks.romBank     <= 9'd1;
            banks.ramBank     <= 4'd0;
            banks.ramEnabled  <= 1'b0;
            banks.bankingMode <= 1'b0;
        end
        else if (regWrite)
        begin
            case (accept.addr[14:13])
                2'b00:
                    banks.ramEnabled <= canEnable && (accept.wdata[3:0] == RamEnableKey);
                2'b01:
                    banks.romBank <= bankMasked;
                2'b10:
                    banks.ramBank <= accept.wdata[3:0];
                default:
                begin
                    // MBC3 clock latch is not modelled
                    if (cfg.kind == mapMbc1)
                        banks.bankingMode <= accept.wdata[0];
                end
            endcase
        end
    end

    // MBC3 clock registers, banks 8 to 12 map to entries 0 to 4
    always_ff @(posedge Clk)
    begin
        if (rtcSelect)
        begin
            if (accept.write)
                rtcRegs[banks.ramBank[2:0]] <= accept.wdata;
            else
                rtcData <= rtcRegs[banks.ramBank[2:0]];
        end
    end

    assert property (@(posedge Clk) disable iff (!rstN)
        (cfg.kind == mapMbc1) |-> (banks.romBank[4:0] != 5'd0));
    assert property (@(posedge Clk) disable iff (!rstN)
        (cfg.kind == mapMbc3) |-> (banks.romBank[6:0] != 7'd0));

endmodule

//--- addressTranslate.sv
`timescale 1ns/1ps

module addressTranslate
#(
    parameter int RomBankBits = 9
)
(
    input  cartMapperPkg::cartCfg_t                    cfg,
    input  cartMapperPkg::bankState_t                  banks,
    input  cartMapperPkg::hostReq_t                    accept,
    output logic [cartMapperPkg::ImageAddrWidth-1:0]   imageAddr,
    output logic                                       imageRead,
    output logic [cartMapperPkg::RamAddrWidth-1:0]     ramAddr,
    output logic                                       ramRead,
    output logic                                       ramWrite,
    output logic [7:0]                                 ramWdata,
    output logic                                       rtcSelect
);
    import cartMapperPkg::*;

    logic       mbc1Large;
    logic [1:0] mbc1High;
    logic [8:0] upperBank;
    logic       ramWindow;
    logic       rtcBank;
    logic       ramHit;
    logic [3:0] ramBankBits;

    // MBC1 with 1 MiB or more takes extra bank bits from the RAM bank register
    assign mbc1Large = (cfg.kind == mapMbc1) && (cfg.romSize >= 4'h5) && (cfg.romSize <= 4'h8);
    assign mbc1High = mbc1Large ? banks.ramBank[1:0] : 2'b00;
    assign upperBank = 9'(banks.romBank[RomBankBits-1:0]);

    // ====================
    // ROM image side
    // ====================

    always_comb
    begin
        imageAddr[13:0] = accept.addr[13:0];
        if (!accept.addr[14])
            // Bank 0 window, moved only in MBC1 mode 1
            imageAddr[ImageAddrWidth-1:14] = banks.bankingMode ? {2'b00, mbc1High, 5'd0} : '0;
        else if (cfg.kind == mapMbc1)
            imageAddr[ImageAddrWidth-1:14] = {2'b00, mbc1High, banks.romBank[4:0]};
        else if (cfg.kind == mapUnsupported)
            imageAddr[ImageAddrWidth-1:14] = '0;
        else
            imageAddr[ImageAddrWidth-1:14] = upperBank;
    end

    assign imageRead = accept.valid && !accept.write && !accept.addr[15];

    // ====================
    // Cartridge RAM side
    // ====================

    assign ramWindow = accept.valid && (accept.addr[15:13] == 3'b101) && banks.ramEnabled;
    assign rtcBank = (cfg.kind == mapMbc3) && cfg.hasTimer
                     && (banks.ramBank >= 4'd8) && (banks.ramBank <= 4'd12);
    assign rtcSelect = ramWindow && rtcBank;
    assign ramHit = ramWindow && !rtcBank;

    // MBC1 pins RAM to bank 0 in mode 0, on small RAM or on large ROM
    assign ramBankBits = ((cfg.kind == mapMbc1)
                          && (!banks.bankingMode || cfg.ramSize < 3'd2 || mbc1Large))
                         ? 4'd0 : banks.ramBank;

    assign ramAddr = {ramBankBits, accept.addr[12:0]};
    assign ramRead = ramHit && !accept.write;
    assign ramWrite = ramHit && accept.write;
    assign ramWdata = accept.wdata;

endmodule

//--- busResult.sv
`timescale 1ns/1ps

module busResult
(
    input  logic                      Clk,
    input  logic                      rstN,
    input  logic                      wbCyc,
    input  logic                      wbStb,
    input  logic                      wbWe,
    input  logic [15:0]               wbAdr,
    input  logic [7:0]                wbDatW,
    input  logic                      cfgReady,
    input  cartMapperPkg::bankState_t banks,
    input  logic                      rtcSelect,
    input  logic [7:0]                rtcData,
    input  logic [7:0]                imageData,
    input  logic [7:0]                ramRdata,
    output cartMapperPkg::hostReq_t   accept,
    output logic                      wbAck,
    output logic [7:0]                wbDatR
);
    import cartMapperPkg::*;

    typedef enum logic [1:0]
    {
        srcNone,
        srcImage,
        srcRam,
        srcRtc
    } readSrc_e;

    readSrc_e readSrc;

    // Held off until the header is in, and for the ack cycle itself
    assign accept.addr = wbAdr;
    assign accept.wdata = wbDatW;
    assign accept.write = wbWe;
    assign accept.valid = wbCyc && wbStb && cfgReady && !wbAck;

    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            wbAck   <= 1'b0;
            readSrc <= srcNone;
        end
        else
        begin
            wbAck <= accept.valid;
            if (accept.valid)
            begin
                if (accept.write)
                    readSrc <= srcNone;
                else if (!accept.addr[15])
                    readSrc <= srcImage;
                else if (rtcSelect)
                    readSrc <= srcRtc;
                else if (accept.addr[15:13] == 3'b101 && banks.ramEnabled)
                    readSrc <= srcRam;
                else
                    readSrc <= srcNone;
            end
        end
    end

    // Memories answer in the ack cycle
    always_comb
    begin
        case (readSrc)
            srcImage: wbDatR = imageData;
            srcRam:   wbDatR = ramRdata;
            srcRtc:   wbDatR = rtcData;
            default:  wbDatR = 8'h00;
        endcase
    end

    assert property (@(posedge Clk) disable iff (!rstN) wbAck |-> $past(wbCyc && wbStb));

endmodule

//--- cartMapper.sv
`timescale 1ns/1ps

module cartMapper
#(
    parameter int RomBankBits = 9
)
(
    input  logic                                     Clk,
    input  logic                                     rstN,
    // Host side
    input  logic                                     wbCyc,
    input  logic                                     wbStb,
    input  logic                                     wbWe,
    input  logic [15:0]                              wbAdr,
    input  logic [7:0]                               wbDatW,
    output logic [7:0]                               wbDatR,
    output logic                                     wbAck,
    // ROM image
    output logic [cartMapperPkg::ImageAddrWidth-1:0] imageAddr,
    output logic                                     imageRead,
    input  logic [7:0]                               imageData,
    // Cartridge RAM
    output logic [cartMapperPkg::RamAddrWidth-1:0]   ramAddr,
    output logic                                     ramRead,
    output logic                                     ramWrite,
    output logic [7:0]                               ramWdata,
    input  logic [7:0]                               ramRdata
);
    import cartMapperPkg::*;

    cartCfg_t                  cfg;
    logic                      cfgReady;
    logic [15:0]               hdrAddr;
    logic                      hdrRead;
    hostReq_t                  accept;
    bankState_t                banks;
    logic [7:0]                rtcData;
    logic                      rtcSelect;
    logic [ImageAddrWidth-1:0] xlatImageAddr;
    logic                      xlatImageRead;

    cartHeaderDecode i_headerDecode
    (
        .Clk       (Clk),
        .rstN      (rstN),
        .imageData (imageData),
        .hdrAddr   (hdrAddr),
        .hdrRead   (hdrRead),
        .cfg       (cfg),
        .cfgReady  (cfgReady)
    );

    bankRegisters #(.RomBankBits(RomBankBits)) i_bankRegisters
    (
        .Clk       (Clk),
        .rstN      (rstN),
        .cfg       (cfg),
        .accept    (accept),
        .rtcSelect (rtcSelect),
        .banks     (banks),
        .rtcData   (rtcData)
    );

    addressTranslate #(.RomBankBits(RomBankBits)) i_addressTranslate
    (
        .cfg       (cfg),
        .banks     (banks),
        .accept    (accept),
        .imageAddr (xlatImageAddr),
        .imageRead (xlatImageRead),
        .ramAddr   (ramAddr),
        .ramRead   (ramRead),
        .ramWrite  (ramWrite),
        .ramWdata  (ramWdata),
        .rtcSelect (rtcSelect)
    );

    busResult i_busResult
    (
        .Clk       (Clk),
        .rstN      (rstN),
        .wbCyc     (wbCyc),
        .wbStb     (wbStb),
        .wbWe      (wbWe),
        .wbAdr     (wbAdr),
        .wbDatW    (wbDatW),
        .cfgReady  (cfgReady),
        .banks     (banks),
        .rtcSelect (rtcSelect),
        .rtcData   (rtcData),
        .imageData (imageData),
        .ramRdata  (ramRdata),
        .accept    (accept),
        .wbAck     (wbAck),
        .wbDatR    (wbDatR)
    );

    // Header reader owns the image port until configured
    assign imageAddr = cfgReady ? xlatImageAddr : {{(ImageAddrWidth - 16){1'b0}}, hdrAddr};
    assign imageRead = cfgReady ? xlatImageRead : hdrRead;

endmodule

//--- tbClockGen.sv
`timescale 1ns/1ps

module tbClockGen
(
    input  logic resetReq,
    output logic Clk,
    output logic rstN
);
    // Cycles left with reset held low
    int holdCount = 16;

    initial
    begin
        Clk  = 1'b0;
        rstN = 1'b0;
    end

    // 4 ns period
    always #2 Clk = ~Clk;

    // A request restarts the 16 cycle hold
    always @(posedge Clk)
    begin
        if (resetReq)
            holdCount <= 16;
        else if (holdCount > 0)
            holdCount <= holdCount - 1;
    end

    // Reset changes on the falling edge like the other stimulus
    always @(negedge Clk)
    begin
        rstN <= (holdCount == 0);
    end

endmodule

//--- tbCartMapper.sv
`timescale 1ns/1ps

module tbCartMapper;

    // Six short tests, each well under 600 cycles including its reset
    localparam int MaxCycles = 4000;
    // Header read plus one transfer fits easily
    localparam int AckLimit = 16;
    // Five header cycles, then one cycle to acknowledge
    localparam int StallAckCycle = 6;

    logic        Clk;
    logic        rstN;
    logic        resetReq = 1'b0;
    logic        wbCyc = 1'b0;
    logic        wbStb = 1'b0;
    logic        wbWe = 1'b0;
    logic [15:0] wbAdr = 16'h0000;
    logic [7:0]  wbDatW = 8'h00;
    logic [7:0]  wbDatR;
    logic        wbAck;
    logic [22:0] imageAddr;
    logic        imageRead;
    logic [7:0]  imageData = 8'h00;
    logic [16:0] ramAddr;
    logic        ramRead;
    logic        ramWrite;
    logic [7:0]  ramWdata;
    logic [7:0]  ramRdata = 8'h00;

    // Header bytes at image 0x0147 to 0x0149
    logic [7:0]  hdrType = 8'h00;
    logic [7:0]  hdrRom = 8'h00;
    logic [7:0]  hdrRam = 8'h00;
    logic [22:0] lastImageAddr = 23'h0;
    logic [7:0]  ramMem [0:131071];
    int          ramWriteCount = 0;

    logic [31:0] lfsrState = 32'h0a4b_57bc;
    int          cycleCount = 0;
    int          errorCount = 0;
    int          testCount = 0;
    int          failedTests = 0;
    int          ackWaitCycles = 0;

    tbClockGen i_clockGen
    (
        .resetReq (resetReq),
        .Clk      (Clk),
        .rstN     (rstN)
    );

    cartMapper #(.RomBankBits(9)) i_dut
    (
        .Clk       (Clk),
        .rstN      (rstN),
        .wbCyc     (wbCyc),
        .wbStb     (wbStb),
        .wbWe      (wbWe),
        .wbAdr     (wbAdr),
        .wbDatW    (wbDatW),
        .wbDatR    (wbDatR),
        .wbAck     (wbAck),
        .imageAddr (imageAddr),
        .imageRead (imageRead),
        .imageData (imageData),
        .ramAddr   (ramAddr),
        .ramRead   (ramRead),
        .ramWrite  (ramWrite),
        .ramWdata  (ramWdata),
        .ramRdata  (ramRdata)
    );

    // ====================
    // Memory models
    // ====================

    // Header bytes, elsewhere low address byte XOR bank bits 21:14
    function automatic logic [7:0] imageByte(input logic [22:0] addr);
        if (addr == 23'h000147)
            return hdrType;
        if (addr == 23'h000148)
            return hdrRom;
        if (addr == 23'h000149)
            return hdrRam;
        return addr[7:0] ^ addr[21:14];
    endfunction

    function automatic logic [7:0] ramFill(input logic [16:0] addr);
        return addr[7:0] ^ addr[15:8] ^ {addr[16], 7'd0};
    endfunction

    initial
    begin
        for (int i = 0; i < 131072; i++)
            ramMem[17'(i)] = ramFill(17'(i));
    end

    // One cycle read latency on both ports
    always @(posedge Clk)
    begin
        if (imageRead)
        begin
            imageData     <= imageByte(imageAddr);
            lastImageAddr <= imageAddr;
        end
        if (ramWrite)
        begin
            ramMem[ramAddr] <= ramWdata;
            ramWriteCount   <= ramWriteCount + 1;
        end
        if (ramRead)
            ramRdata <= ramMem[ramAddr];
    end

    // Run limit
    always @(posedge Clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= MaxCycles)
        begin
            $display("Run did not finish within %0d cycles", MaxCycles);
            $display("Test FAILED");
            $finish;
        end
    end

    // ====================
    // Helpers
    // ====================

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] takeRandom(input int bitCount);
        logic [31:0] value;
        int          i;
        value = '0;
        for (i = 0; i < bitCount; i++)
        begin
            lfsrState = lfsrStep(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
        return value;
    endfunction

    task automatic reportMismatch(input string name, input logic [31:0] expVal,
                                  input logic [31:0] gotVal);
        errorCount++;
        $display("[ERROR] %0t: %s expected 0x%0h, got 0x%0h", $time, name, expVal, gotVal);
    endtask

    // Loads new header bytes and waits for reset release
    task automatic restartCart(input logic [7:0] cartType, input logic [7:0] romSize,
                               input logic [7:0] ramSize);
        hdrType = cartType;
        hdrRom  = romSize;
        hdrRam  = ramSize;
        @(negedge Clk);
        resetReq = 1'b1;
        @(negedge Clk);
        resetReq = 1'b0;
        @(posedge rstN);
    endtask

    task automatic waitAck(output int cycles);
        cycles = 0;
        do
        begin
            @(negedge Clk);
            cycles++;
        end
        while (!wbAck && cycles < AckLimit);
    endtask

    task automatic busRead(input logic [15:0] addr, output logic [7:0] data);
        int cycles;
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe  = 1'b0;
        wbAdr = addr;
        data  = 8'h00;
        waitAck(cycles);
        ackWaitCycles = cycles;
        if (wbAck)
            data = wbDatR;
        else
        begin
            errorCount++;
            $display("%0t: read of 0x%h got no acknowledge", $time, addr);
        end
        wbCyc = 1'b0;
        wbStb = 1'b0;
        @(negedge Clk);
    endtask

    task automatic busWrite(input logic [15:0] addr, input logic [7:0] data);
        int cycles;
        wbCyc  = 1'b1;
        wbStb  = 1'b1;
        wbWe   = 1'b1;
        wbAdr  = addr;
        wbDatW = data;
        waitAck(cycles);
        if (!wbAck)
        begin
            errorCount++;
            $display("%0t: write to 0x%h got no acknowledge", $time, addr);
        end
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe  = 1'b0;
        @(negedge Clk);
    endtask

    // Read data and the image address that reached the ROM model
    task automatic checkImageRead(input logic [15:0] hostAddr, input logic [22:0] expAddr);
        logic [7:0] expData;
        logic [7:0] got;
        expData = imageByte(expAddr);
        busRead(hostAddr, got);
        if (got !== expData)
            reportMismatch("wbDatR", 32'(expData), 32'(got));
        if (lastImageAddr !== expAddr)
            reportMismatch("imageAddr", 32'(expAddr), 32'(lastImageAddr));
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        testCount++;
        if (errorCount == errorsBefore)
            $display("%s: passed", name);
        else
        begin
            failedTests++;
            $display("%s: failed with %0d errors", name, errorCount - errorsBefore);
        end
    endtask

    // ====================
    // Directed tests
    // ====================

    task automatic romOnlyTest();
        int          errs;
        logic [15:0] addr;
        logic [7:0]  got;
        errs = errorCount;
        restartCart(8'h00, 8'h01, 8'h00);
        repeat (16)
        begin
            addr = 16'(takeRandom(15));
            checkImageRead(addr, {8'd0, addr[14:0]});
        end
        // Register writes must not move anything
        busWrite(16'h2000, 8'h03);
        busWrite(16'h0000, 8'h0A);
        busWrite(16'h4000, 8'h02);
        busWrite(16'h6000, 8'h01);
        repeat (8)
        begin
            addr = {2'b01, 14'(takeRandom(14))};
            checkImageRead(addr, {8'd0, addr[14:0]});
        end
        busRead(16'hA000, got);
        if (got !== 8'h00)
            reportMismatch("wbDatR", 32'h0, 32'(got));
        finishTest("ROM only", errs);
    endtask

    task automatic mbc1BankTest();
        int          errs;
        logic [13:0] offset;
        logic [7:0]  data;
        logic [7:0]  got;
        errs = errorCount;
        restartCart(8'h03, 8'h04, 8'h03);
        offset = 14'(takeRandom(14));
        // Bank 0 is remapped to bank 1
        busWrite(16'h2000, 8'h00);
        checkImageRead({2'b01, offset}, {9'd1, offset});
        busWrite(16'h2000, 8'h05);
        checkImageRead({2'b01, offset}, {9'd5, offset});
        // RAM enable, mode 1, RAM bank 2
        busWrite(16'h0000, 8'h0A);
        busWrite(16'h6000, 8'h01);
        busWrite(16'h4000, 8'h02);
        checkImageRead(16'h0100, 23'h000100);
        data = 8'(takeRandom(8));
        busWrite(16'hA123, data);
        busRead(16'hA123, got);
        if (got !== data)
            reportMismatch("wbDatR", 32'(data), 32'(got));
        if (ramMem[{4'd2, 13'h0123}] !== data)
            reportMismatch("ramMem", 32'(data), 32'(ramMem[{4'd2, 13'h0123}]));
        // Disabled window reads as zero
        busWrite(16'h0000, 8'h00);
        busRead(16'hA123, got);
        if (got !== 8'h00)
            reportMismatch("wbDatR", 32'h0, 32'(got));
        finishTest("MBC1 banking", errs);
    endtask

    task automatic mbc1LargeTest();
        int          errs;
        logic [13:0] offset;
        errs = errorCount;
        restartCart(8'h01, 8'h06, 8'h00);
        offset = 14'(takeRandom(14));
        busWrite(16'h6000, 8'h01);
        busWrite(16'h4000, 8'h01);
        busWrite(16'h2000, 8'h01);
        // RAM bank bits land on image bits 20:19 in both windows
        checkImageRead({2'b00, offset}, {9'h020, offset});
        checkImageRead({2'b01, offset}, {9'h021, offset});
        finishTest("MBC1 large ROM", errs);
    endtask

    task automatic mbc5BankTest();
        int          errs;
        logic [13:0] offset;
        errs = errorCount;
        restartCart(8'h1B, 8'h08, 8'h03);
        offset = 14'(takeRandom(14));
        busWrite(16'h2000, 8'h00);
        checkImageRead({2'b01, offset}, {9'h000, offset});
        busWrite(16'h2000, 8'h34);
        busWrite(16'h3000, 8'h01);
        checkImageRead({2'b01, offset}, {9'h134, offset});
        finishTest("MBC5 banking", errs);
    endtask

    task automatic mbc3ClockTest();
        int         errs;
        int         writesBefore;
        int         bank;
        logic [7:0] clockBytes [5];
        logic [7:0] data;
        logic [7:0] got;
        errs = errorCount;
        restartCart(8'h10, 8'h02, 8'h03);
        busWrite(16'h0000, 8'h0A);
        writesBefore = ramWriteCount;
        for (bank = 8; bank <= 12; bank++)
        begin
            clockBytes[bank - 8] = 8'(takeRandom(8));
            busWrite(16'h4000, 8'(bank));
            busWrite(16'hA010, clockBytes[bank - 8]);
        end
        for (bank = 8; bank <= 12; bank++)
        begin
            busWrite(16'h4000, 8'(bank));
            busRead(16'hA010, got);
            if (got !== clockBytes[bank - 8])
                reportMismatch("wbDatR", 32'(clockBytes[bank - 8]), 32'(got));
        end
        if (ramWriteCount != writesBefore)
        begin
            errorCount++;
            $display("%0t: clock register access wrote to cartridge RAM", $time);
        end
        // Ordinary RAM bank
        busWrite(16'h4000, 8'h01);
        data = 8'(takeRandom(8));
        busWrite(16'hA456, data);
        if (ramMem[{4'd1, 13'h0456}] !== data)
            reportMismatch("ramMem", 32'(data), 32'(ramMem[{4'd1, 13'h0456}]));
        busRead(16'hA456, got);
        if (got !== data)
            reportMismatch("wbDatR", 32'(data), 32'(got));
        finishTest("MBC3 clock", errs);
    endtask

    task automatic startupStallTest();
        int errs;
        int extraAcks;
        errs = errorCount;
        extraAcks = 0;
        // Request goes out in the same cycle reset is released
        restartCart(8'h00, 8'h00, 8'h00);
        checkImageRead(16'h1234, 23'h001234);
        if (ackWaitCycles != StallAckCycle)
            reportMismatch("wbAck cycle", 32'(StallAckCycle), 32'(ackWaitCycles));
        repeat (4)
        begin
            @(negedge Clk);
            if (wbAck)
                extraAcks++;
        end
        if (extraAcks != 0)
        begin
            errorCount++;
            $display("%0t: %0d extra acknowledges after one request", $time, extraAcks);
        end
        finishTest("Start-up stall", errs);
    endtask

    // ====================
    // Sequence
    // ====================

    initial
    begin
        romOnlyTest();
        mbc1BankTest();
        mbc1LargeTest();
        mbc5BankTest();
        mbc3ClockTest();
        startupStallTest();
        $display("Tests run: %0d, failed: %0d, errors: %0d", testCount, failedTests,
                 errorCount);
        if (errorCount == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

//--- compile.f
cartMapperPkg.sv
cartHeaderDecode.sv
bankRegisters.sv
addressTranslate.sv
busResult.sv
cartMapper.sv
tbClockGen.sv
tbCartMapper.sv

//--- Makefile
VERILATOR  = verilator
SIM_FLAGS  = --binary --timing --assert
LINT_FLAGS = --lint-only --timing
TOP        = tbCartMapper
FILELIST   = compile.f
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "Test OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
